//--- sim.f
divPkg.sv
divCtrlIf.sv
creditFifo.sv
stepCounter.sv
divControl.sv
divDatapath.sv
respCreditGate.sv
divUnit.sv
divChecker.sv
divTb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := divTb
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert -Wno-fatal
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -Mdir $(OBJ_DIR)
FAIL_MSG   := CHECKS FAILED
PASS_MSG   := ALL CHECKS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- divTb.sv
module divTb;

    import divPkg::*;

    localparam int REQ_DEPTH  = 2;
    localparam int RESP_DEPTH = 2;
    localparam int NUM_REQ    = 200;
    localparam int TIMEOUT    = NUM_REQ * 40 + 1000;
    // A small cap on response credits lets each credit gap back up the result queue
    localparam int CREDIT_CAP = 2;
    // Credits stop for GAP_LEN cycles at the end of every GAP_PERIOD
    localparam int GAP_PERIOD = 2000;
    localparam int GAP_LEN    = 250;
    // Pop to push takes 36 cycles and the FSM idles one more before the next pop
    localparam int JOB_CYCLES = 37;

    logic              clk = 1'b0;
    logic              arstN;
    logic              reqValid;
    logic [DATA_W-1:0] reqDividend;
    logic [DATA_W-1:0] reqDivisor;
    logic              reqCredit;
    logic              respCredit;
    logic              respValid;
    logic [DATA_W-1:0] respQuot;
    logic              respDiv0;
    logic              endOfTest;
    int                seed;
    int                cycle = 0;
    int                sent = 0;
    int                reqCredits = REQ_DEPTH;
    int                grantsOpen = 0;
    int                starvedRun = 0;
    int                longestStarve = 0;
    int                stallErrors = 0;
    int                valueErrors;
    int                protocolErrors;
    int                resultCount;

    always #10 clk = ~clk;

    divUnit #(.REQ_DEPTH(REQ_DEPTH), .RESP_DEPTH(RESP_DEPTH)) dut0 (
        .clk(clk), .arstN(arstN), .reqValid(reqValid), .reqDividend(reqDividend),
        .reqDivisor(reqDivisor), .reqCredit(reqCredit), .respCredit(respCredit),
        .respValid(respValid), .respQuot(respQuot), .respDiv0(respDiv0)
    );

    divChecker #(.TOTAL(NUM_REQ)) checker0 (
        .clk(clk), .arstN(arstN), .reqValid(reqValid), .reqDividend(reqDividend),
        .reqDivisor(reqDivisor), .reqCredit(reqCredit), .respCredit(respCredit),
        .respValid(respValid), .respQuot(respQuot), .respDiv0(respDiv0),
        .endOfTest(endOfTest), .valueErrors(valueErrors),
        .protocolErrors(protocolErrors), .resultCount(resultCount)
    );

    // Mixes plain random operands with small, unit, zero and extreme values
    task automatic makeOperands(output logic [DATA_W-1:0] dvd, output logic [DATA_W-1:0] dvs);
        int kind;
        kind = ($random(seed) & 32'h7fffffff) % 8;
        dvd  = $random(seed);
        dvs  = $random(seed);
        case (kind)
            2: begin
                dvd = $random(seed) % 17;
                dvs = $random(seed) % 17;
            end
            3: dvs = ($random(seed) & 1) ? 32'h1 : 32'hffffffff;
            4: dvs = '0;
            5: dvd = ($random(seed) & 1) ? 32'h80000000 : 32'h7fffffff;
            6: dvs = $random(seed) % 8;
            7: dvs = ($random(seed) & 1) ? 32'h80000000 : 32'h7fffffff;
            default: ;
        endcase
        // The one overflowing quotient is outside the unit's range
        if (dvd == 32'h80000000 && dvs == 32'hffffffff) begin
            dvs = 32'h1;
        end
    endtask

    task automatic driveRequest();
        logic [DATA_W-1:0] dvd;
        logic [DATA_W-1:0] dvs;
        if (reqCredit) begin
            reqCredits++;
        end
        reqValid <= 1'b0;
        // A run longer than one job means the unit held its requests under back-pressure
        if (sent < NUM_REQ && reqCredits == 0) begin
            starvedRun++;
            if (starvedRun > longestStarve) begin
                longestStarve = starvedRun;
            end
        end else begin
            starvedRun = 0;
        end
        if (sent < NUM_REQ && reqCredits > 0 && ($random(seed) & 32'hff) < 180) begin
            makeOperands(dvd, dvs);
            reqValid    <= 1'b1;
            reqDividend <= dvd;
            reqDivisor  <= dvs;
            reqCredits--;
            sent++;
        end
    endtask

    task automatic grantResponseCredit();
        logic inGap;
        if (respValid) begin
            grantsOpen--;
        end
        inGap = (cycle % GAP_PERIOD) >= (GAP_PERIOD - GAP_LEN);
        respCredit <= 1'b0;
        if (!inGap && grantsOpen < CREDIT_CAP && (($random(seed) & 32'h7fffffff) % 100) < 30) begin
            respCredit <= 1'b1;
            grantsOpen++;
        end
    endtask

    initial begin
        seed = 32'hc9041542;
        arstN       <= 1'b0;
        reqValid    <= 1'b0;
        reqDividend <= '0;
        reqDivisor  <= '0;
        respCredit  <= 1'b0;
        endOfTest   <= 1'b0;
        repeat (8) @(posedge clk);
        arstN <= 1'b1;
        // Idle stretch with neither requests nor credits, both outputs must stay low
        repeat (10) @(posedge clk);
        while (resultCount < NUM_REQ && cycle < TIMEOUT) begin
            @(posedge clk);
            cycle++;
            driveRequest();
            grantResponseCredit();
            @(negedge clk);
        end
        if (cycle >= TIMEOUT) begin
            $display("Timeout after %0d cycles with %0d of %0d results received",
                     cycle, resultCount, NUM_REQ);
            $display("CHECKS FAILED");
        end else begin
            // Keep granting a while so a duplicated result would still show up
            repeat (60) begin
                @(posedge clk);
                cycle++;
                driveRequest();
                grantResponseCredit();
            end
            @(posedge clk);
            respCredit <= 1'b0;
            endOfTest  <= 1'b1;
            repeat (2) @(negedge clk);
            if (longestStarve <= JOB_CYCLES) begin
                stallErrors++;
                $display("The unit never stalled on a full result queue");
            end
            $display("Summary: %0d value errors, %0d protocol errors, %0d results for %0d requests",
                     valueErrors, protocolErrors + stallErrors, resultCount, sent);
            if (valueErrors == 0 && protocolErrors == 0 && stallErrors == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
        end
        $finish;
    end

endmodule

//--- divChecker.sv
module divChecker #(
    parameter int TOTAL = 200
) (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      reqValid,
    input  logic [divPkg::DATA_W-1:0] reqDividend,
    input  logic [divPkg::DATA_W-1:0] reqDivisor,
    input  logic                      reqCredit,
    input  logic                      respCredit,
    input  logic                      respValid,
    input  logic [divPkg::DATA_W-1:0] respQuot,
    input  logic                      respDiv0,
    input  logic                      endOfTest,
    output int                        valueErrors,
    output int                        protocolErrors,
    output int                        resultCount
);

    import divPkg::*;

    logic [DATA_W-1:0] expQuot [$];
    logic              expDiv0 [$];
    int                sentCount;
    int                creditCount;
    int                grantsOpen;
    logic              endDone;

    // Signed division rounding toward zero, a zero divisor leaves the quotient open
    function automatic logic [DATA_W-1:0] truncQuot(input logic signed [DATA_W-1:0] dvd,
                                                    input logic signed [DATA_W-1:0] dvs);
        if (dvs == 0) begin
            return '0;
        end
        return dvd / dvs;
    endfunction

    always @(posedge clk or negedge arstN) begin
        logic [DATA_W-1:0] wantQuot;
        logic              wantDiv0;
        if (!arstN) begin
            expQuot.delete();
            expDiv0.delete();
            sentCount      = 0;
            creditCount    = 0;
            grantsOpen     = 0;
            valueErrors    = 0;
            protocolErrors = 0;
            resultCount    = 0;
            endDone        = 1'b0;
        end else begin
            // A result may only spend credits granted on earlier edges
            if (respValid) begin
                if (grantsOpen == 0) begin
                    protocolErrors++;
                    $display("%0t: respValid came while no response credit was granted", $time);
                end else begin
                    grantsOpen--;
                end
                if (expQuot.size() == 0) begin
                    protocolErrors++;
                    $display("%0t: a result came out with no request pending", $time);
                end else begin
                    wantQuot = expQuot.pop_front();
                    wantDiv0 = expDiv0.pop_front();
                    if (respDiv0 !== wantDiv0) begin
                        valueErrors++;
                        $display("ERROR %0t respDiv0 expected %b actual %b",
                                 $time, wantDiv0, respDiv0);
                    end else if (!wantDiv0 && respQuot !== wantQuot) begin
                        valueErrors++;
                        $display("ERROR %0t respQuot expected %h actual %h",
                                 $time, wantQuot, respQuot);
                    end
                end
                resultCount++;
            end
            if (respCredit) begin
                grantsOpen++;
            end
            // A request pushed on this edge cannot be the one whose credit returns now
            if (reqCredit) begin
                creditCount++;
                if (creditCount > sentCount) begin
                    protocolErrors++;
                    $display("%0t: reqCredit pulse %0d came with only %0d requests sent",
                             $time, creditCount, sentCount);
                end
            end
            if (reqValid) begin
                expQuot.push_back(truncQuot(reqDividend, reqDivisor));
                expDiv0.push_back(reqDivisor == '0);
                sentCount++;
            end
            if (endOfTest && !endDone) begin
                endDone = 1'b1;
                if (sentCount != TOTAL || resultCount != TOTAL) begin
                    protocolErrors++;
                    $display("%0d requests were sent and %0d results came back, %0d were due",
                             sentCount, resultCount, TOTAL);
                end
                if (creditCount != sentCount) begin
                    protocolErrors++;
                    $display("%0d reqCredit pulses were returned for %0d requests",
                             creditCount, sentCount);
                end
            end
        end
    end

endmodule

//--- divUnit.sv
module divUnit #(
    parameter int REQ_DEPTH  = 2,
    parameter int RESP_DEPTH = 2
) (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      reqValid,
    input  logic [divPkg::DATA_W-1:0] reqDividend,
    input  logic [divPkg::DATA_W-1:0] reqDivisor,
    output logic                      reqCredit,
    input  logic                      respCredit,
    output logic                      respValid,
    output logic [divPkg::DATA_W-1:0] respQuot,
    output logic                      respDiv0
);

    import divPkg::*;

    divReq_t  reqIn;
    divReq_t  reqHead;
    logic     reqHeadValid;
    logic     reqPop;
    divResp_t respIn;
    divResp_t respHead;
    logic     respPush;
    logic     respPop;
    logic     respFull;
    logic     stepClear;
    logic     stepEnable;
    logic     stepLast;

    logic [$clog2(RESP_DEPTH+1)-1:0] respCount;

    divCtrlIf ctrlBus ();

    assign reqIn.dividend = reqDividend;
    assign reqIn.divisor  = reqDivisor;
    assign respFull       = (respCount == RESP_DEPTH);
    assign respQuot       = respHead.quot;
    assign respDiv0       = respHead.div0;

    creditFifo #(.T(divReq_t), .DEPTH(REQ_DEPTH)) reqFifo (
        .clk(clk), .arstN(arstN), .pushValid(reqValid), .pushData(reqIn),
        .pop(reqPop), .popValid(reqHeadValid), .popData(reqHead),
        .creditReturn(reqCredit), .count()
    );

    divControl control (
        .clk(clk), .arstN(arstN), .reqValid(reqHeadValid), .reqPop(reqPop),
        .last(stepLast), .respFull(respFull), .respPush(respPush), .ctrl(ctrlBus),
        .stepClear(stepClear), .stepEnable(stepEnable)
    );

    stepCounter counter (
        .clk(clk), .arstN(arstN), .clear(stepClear), .enable(stepEnable), .last(stepLast)
    );

    divDatapath datapath (
        .clk(clk), .arstN(arstN), .reqData(reqHead), .dp(ctrlBus), .result(respIn)
    );

    creditFifo #(.T(divResp_t), .DEPTH(RESP_DEPTH)) respFifo (
        .clk(clk), .arstN(arstN), .pushValid(respPush), .pushData(respIn),
        .pop(respPop), .popValid(), .popData(respHead),
        .creditReturn(), .count(respCount)
    );

    respCreditGate #(.DEPTH(RESP_DEPTH)) respGate (
        .clk(clk), .arstN(arstN), .creditIn(respCredit), .queueCount(respCount),
        .pop(respPop), .respValid(respValid)
    );

endmodule

//--- respCreditGate.sv
module respCreditGate #(
    parameter int DEPTH = 2
) (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       creditIn,
    input  logic [$clog2(DEPTH+1)-1:0] queueCount,
    output logic                       pop,
    output logic                       respValid
);

    // Headroom for credits granted ahead of queued results
    localparam int MARGIN     = 8;
    localparam int MAX_CREDIT = DEPTH + MARGIN;
    localparam int CRED_W     = $clog2(MAX_CREDIT + 1);

    logic [CRED_W-1:0] credits;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            credits <= '0;
        end else begin
            case ({creditIn, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // A result goes out as soon as both a credit and a queued entry exist
    assign pop       = (credits != '0) && (queueCount != '0);
    assign respValid = pop;

    assert property (@(posedge clk) disable iff (!arstN)
        (creditIn && !pop) |-> (credits < CRED_W'(MAX_CREDIT)));

endmodule

//--- divDatapath.sv
module divDatapath (
    input  logic             clk,
    input  logic             arstN,
    input  divPkg::divReq_t  reqData,
    divCtrlIf.dp             dp,
    output divPkg::divResp_t result
);

    import divPkg::*;

    logic [DATA_W-1:0] negIn;
    logic [DATA_W-1:0] negOut;
    logic [DATA_W-1:0] dvsReg;
    logic [DATA_W-1:0] quotReg;
    logic [DATA_W:0]   remReg;
    logic [DATA_W:0]   remShift;
    logic [DATA_W:0]   remNext;
    logic              dvdSign;
    logic              dvsSign;
    logic              div0Reg;
    divResp_t          resultReg;

    // One negator serves the dividend, then the divisor, then the quotient
    assign negIn  = dp.signFix ? quotReg : (dp.loadDvs ? dvsReg : reqData.dividend);
    assign negOut = ~negIn + 1'b1;

    // Next partial remainder of the non-restoring step
    assign remShift = {remReg[DATA_W-1:0], quotReg[DATA_W-1]};
    assign remNext  = remReg[DATA_W] ? remShift + {1'b0, dvsReg}
                                     : remShift - {1'b0, dvsReg};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dvdSign <= 1'b0;
            dvsSign <= 1'b0;
            div0Reg <= 1'b0;
        end else if (dp.loadDvd) begin
            dvdSign <= reqData.dividend[DATA_W-1];
        end else if (dp.loadDvs) begin
            dvsSign <= dvsReg[DATA_W-1];
            div0Reg <= (dvsReg == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (dp.loadDvd) begin
            // Divisor is held raw until the negator is free next cycle
            remReg  <= '0;
            quotReg <= reqData.dividend[DATA_W-1] ? negOut : reqData.dividend;
            dvsReg  <= reqData.divisor;
        end else if (dp.loadDvs) begin
            dvsReg <= dvsReg[DATA_W-1] ? negOut : dvsReg;
        end else if (dp.step) begin
            // A non-negative new remainder means this quotient bit is one
            remReg  <= remNext;
            quotReg <= {quotReg[DATA_W-2:0], ~remNext[DATA_W]};
        end
    end

    always_ff @(posedge clk) begin
        if (dp.capture) begin
            resultReg.quot <= dp.signFix ? negOut : quotReg;
            resultReg.div0 <= div0Reg;
        end
    end

    assign dp.signsDiffer = dvdSign ^ dvsSign;
    assign result         = resultReg;

    // The divisor fix-up relies on the FSM giving it the very next cycle
    assert property (@(posedge clk) disable iff (!arstN)
        dp.loadDvd |=> dp.loadDvs);

endmodule

//--- divControl.sv
module divControl (
    input  logic   clk,
    input  logic   arstN,
    input  logic   reqValid,
    output logic   reqPop,
    input  logic   last,
    input  logic   respFull,
    output logic   respPush,
    divCtrlIf.ctrl ctrl,
    output logic   stepClear,
    output logic   stepEnable
);

    import divPkg::*;

    divState_t state;
    divState_t stateNext;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (reqValid) begin
                    stateNext = LOAD_DVD;
                end
            end
            LOAD_DVD: stateNext = LOAD_DVS;
            LOAD_DVS: stateNext = ITER;
            ITER: begin
                if (last) begin
                    stateNext = SIGN_FIX;
                end
            end
            SIGN_FIX: stateNext = PUSH;
            PUSH: begin
                // Result queue back-pressure holds the whole unit here
                if (!respFull) begin
                    stateNext = IDLE;
                end
            end
            default: stateNext = IDLE;
        endcase
    end

    // The request leaves the queue while the dividend is latched
    assign reqPop       = (state == LOAD_DVD);
    assign ctrl.loadDvd = (state == LOAD_DVD);
    assign ctrl.loadDvs = (state == LOAD_DVS);
    assign stepClear    = (state == LOAD_DVS);
    assign ctrl.step    = (state == ITER);
    assign stepEnable   = (state == ITER);

    // The negator only takes the quotient when the signs call for it
    assign ctrl.signFix = (state == SIGN_FIX) && ctrl.signsDiffer;
    assign ctrl.capture = (state == SIGN_FIX);
    assign respPush     = (state == PUSH) && !respFull;

    // The counter has to end the iteration after exactly one step per bit
    assert property (@(posedge clk) disable iff (!arstN)
        (state == LOAD_DVS) |=> (state == ITER) [*DATA_W] ##1 (state == SIGN_FIX));

endmodule

//--- stepCounter.sv
module stepCounter (
    input  logic clk,
    input  logic arstN,
    input  logic clear,
    input  logic enable,
    output logic last
);

    import divPkg::*;

    logic [STEP_W-1:0] count;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (enable) begin
            count <= count + 1'b1;
        end
    end

    // High during the final iteration, one per quotient bit
    assign last = (count == STEP_W'(DATA_W - 1));

    // Once the final step is taken no further step may come before a new job
    assert property (@(posedge clk) disable iff (!arstN)
        (enable && last) |=> (!enable until clear));

endmodule

//--- creditFifo.sv
module creditFifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 2
) (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       pushValid,
    input  T                           pushData,
    input  logic                       pop,
    output logic                       popValid,
    output T                           popData,
    output logic                       creditReturn,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;

    // Pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({pushValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pushValid) begin
            mem[wrPtr] <= pushData;
        end
    end

    assign popValid = (count != '0);
    assign popData  = mem[rdPtr];

    // The slot frees on this edge, so its credit goes back in the same cycle
    assign creditReturn = pop & popValid;

    // The producer must respect its credits
    assert property (@(posedge clk) disable iff (!arstN)
        pushValid |-> (count < DEPTH));

    assert property (@(posedge clk) disable iff (!arstN)
        pop |-> popValid);

endmodule

//--- divCtrlIf.sv
interface divCtrlIf;

    // Strobes from the FSM, each one selects a single datapath action
    logic loadDvd;
    logic loadDvs;
    logic step;
    logic signFix;
    logic capture;

    // Status back from the datapath
    logic signsDiffer;

    modport ctrl (
        output loadDvd,
        output loadDvs,
        output step,
        output signFix,
        output capture,
        input  signsDiffer
    );

    modport dp (
        input  loadDvd,
        input  loadDvs,
        input  step,
        input  signFix,
        input  capture,
        output signsDiffer
    );

endinterface

//--- divPkg.sv
package divPkg;

    // Operand and quotient width
    localparam int DATA_W = 32;

    // Step counter width, wide enough to count DATA_W iterations
    localparam int STEP_W = 6;

    // One queued division request
    typedef struct packed {
        logic [DATA_W-1:0] dividend;
        logic [DATA_W-1:0] divisor;
    } divReq_t;

    // One finished result, the quotient is meaningless when div0 is set
    typedef struct packed {
        logic [DATA_W-1:0] quot;
        logic              div0;
    } divResp_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_DVD,
        LOAD_DVS,
        ITER,
        SIGN_FIX,
        PUSH
    } divState_t;

endpackage
